// File: src/histPkg.sv
package histPkg;

    // histogram geometry
    localparam int binW = 6;              // 64 time bins per pixel
    localparam int pixW = 2;              // up to 4 pixels
    localparam int cntW = 12;             // bin count width
    localparam int addrW = pixW + binW;   // pixel above bin

    // largest count a bin can hold, increments stop here
    localparam logic [cntW-1:0] cntMax = {cntW{1'b1}};

    // one photon hit, qualified by evValid
    typedef struct packed {
        logic [pixW-1:0] pixel;
        logic [binW-1:0] bin;
    } hitEvent_t;

    // one peer's request to both RAM ports
    typedef struct packed {
        logic             rdEn;
        logic [addrW-1:0] rdAddr;
        logic             wrEn;
        logic [addrW-1:0] wrAddr;
        logic [cntW-1:0]  wrData;
    } ramReq_t;

    // per-pixel peak reported at frame end
    typedef struct packed {
        logic [pixW-1:0] pixel;
        logic [binW-1:0] bin;
        logic [cntW-1:0] count;
    } peakResult_t;

endpackage

// File: src/histRam.sv
`timescale 1ns/1ps

module histRam (
    input  logic                      clk,
    input  histPkg::ramReq_t          ramReq,
    output logic [histPkg::cntW-1:0]  rdData
);
    import histPkg::*;

    localparam int depth = 1 << addrW;   // 4 pixels x 64 bins

    logic [cntW-1:0] mem [0:depth-1];

    // all bins start empty, the search clears them afterwards
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        if (ramReq.wrEn) begin
            mem[ramReq.wrAddr] <= ramReq.wrData;
        end
        if (ramReq.rdEn) begin
            rdData <= mem[ramReq.rdAddr];   // valid one cycle later
        end
    end

endmodule

// File: src/ramArbiter.sv
`timescale 1ns/1ps

module ramArbiter (
    input  logic             clk,
    input  logic             res,
    input  histPkg::ramReq_t accReq,
    input  histPkg::ramReq_t srchReq,
    output logic             accGrant,
    output logic             srchGrant,
    output histPkg::ramReq_t ramReq
);
    import histPkg::*;

    logic accWants;
    logic srchWants;

    assign accWants = accReq.rdEn | accReq.wrEn;     // either port
    assign srchWants = srchReq.rdEn | srchReq.wrEn;

    // accumulator has fixed priority
    always_comb begin
        if (accWants) begin
            ramReq = accReq;
        end else begin
            ramReq = srchReq;
        end
    end

    // grants report what reached the RAM in the previous cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            accGrant <= 1'b0;
            srchGrant <= 1'b0;
        end else begin
            accGrant <= accWants;
            srchGrant <= !accWants && srchWants;   // loser holds its request
        end
    end

endmodule

// File: src/binAccumulator.sv
`timescale 1ns/1ps

module binAccumulator #(
    parameter int pixels = 3
) (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      evValid,
    input  histPkg::hitEvent_t        ev,
    output histPkg::ramReq_t          accReq,
    input  logic                      accGrant,
    input  logic [histPkg::cntW-1:0]  rdData,
    output logic                      idle
);
    import histPkg::*;

    // stage 1, read issue
    logic             s1Valid;
    logic [addrW-1:0] s1Addr;

    // stage 2, increment and write
    logic             s2Valid;
    logic             s2Live;
    logic [addrW-1:0] s2Addr;
    logic [cntW-1:0]  base;
    logic [cntW-1:0]  sum;

    // last stage-2 write, for back-to-back hits
    logic             fwdValid;
    logic [addrW-1:0] fwdAddr;
    logic [cntW-1:0]  fwdData;

    assign s1Valid = evValid && (int'(ev.pixel) < pixels);   // drop unused pixels
    assign s1Addr = {ev.pixel, ev.bin};

    // rdData belongs to us only if our read was granted
    assign s2Live = s2Valid && accGrant;

    // the RAM read missed a write made in the same cycle
    always_comb begin
        if (fwdValid && (fwdAddr == s2Addr)) begin
            base = fwdData;
        end else begin
            base = rdData;
        end
    end

    assign sum = (base == cntMax) ? base : base + 1'b1;   // saturate at 4095

    always_comb begin
        accReq.rdEn = s1Valid;
        accReq.rdAddr = s1Addr;
        accReq.wrEn = s2Live;
        accReq.wrAddr = s2Addr;
        accReq.wrData = sum;
    end

    assign idle = !s1Valid && !s2Valid;   // nothing in flight

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s2Valid <= 1'b0;
            fwdValid <= 1'b0;
        end else begin
            s2Valid <= s1Valid;
            fwdValid <= s2Live;   // only ever one cycle old
        end
    end

    always_ff @(posedge clk) begin
        s2Addr <= s1Addr;
        fwdAddr <= s2Addr;
        fwdData <= sum;
    end

endmodule

// File: src/peakSearch.sv
`timescale 1ns/1ps

module peakSearch #(
    parameter int pixels = 3
) (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      frameEnd,
    input  logic                      idle,
    output histPkg::ramReq_t          srchReq,
    input  logic                      srchGrant,
    input  logic [histPkg::cntW-1:0]  rdData,
    output logic                      peakValid,
    output histPkg::peakResult_t      peak,
    output logic                      busy,
    output logic                      done
);
    import histPkg::*;

    typedef enum logic [1:0] {sIdle, sWait, sScan, sFinish} state_t;

    localparam logic [addrW-1:0] lastAddr = {pixW'(pixels - 1), {binW{1'b1}}};

    state_t           state;
    ramReq_t          curReq;     // request presented last cycle
    ramReq_t          newReq;
    logic [addrW-1:0] nextAddr;   // next bin to read
    logic             moreRd;
    logic             startScan;
    logic             issue;
    logic             scanEnd;

    logic             cmpValid;
    logic [pixW-1:0]  cmpPixel;
    logic [binW-1:0]  cmpBin;
    logic             take;
    logic [cntW-1:0]  maxCount;
    logic [binW-1:0]  maxBin;
    logic [cntW-1:0]  bestCount;
    logic [binW-1:0]  bestBin;

    assign startScan = idle && ((state == sIdle && frameEnd) || state == sWait);

    // move on once the last request went through, else hold it
    assign issue = (state == sScan) && (srchGrant || !(curReq.rdEn || curReq.wrEn));

    always_comb begin
        newReq.rdEn = moreRd;
        newReq.rdAddr = nextAddr;
        newReq.wrEn = srchGrant && curReq.rdEn;   // clear the bin just read
        newReq.wrAddr = curReq.rdAddr;
        newReq.wrData = '0;
        srchReq = issue ? newReq : curReq;
    end

    assign scanEnd = issue && !newReq.rdEn && !newReq.wrEn;

    // compare the bin whose read was granted last cycle
    assign cmpValid = srchGrant && curReq.rdEn;
    assign cmpPixel = curReq.rdAddr[addrW-1:binW];
    assign cmpBin = curReq.rdAddr[binW-1:0];
    assign take = (cmpBin == '0) || (rdData > maxCount);   // strict, lowest bin wins ties
    assign bestCount = take ? rdData : maxCount;
    assign bestBin = take ? cmpBin : maxBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= sIdle;
            curReq <= '0;
            nextAddr <= '0;
            moreRd <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
            peakValid <= 1'b0;
        end else begin
            curReq <= srchReq;
            done <= 1'b0;
            peakValid <= cmpValid && (cmpBin == '1);   // pixel's last bin
            if (startScan) begin
                state <= sScan;
                busy <= 1'b1;
                nextAddr <= '0;
                moreRd <= 1'b1;
            end else begin
                case (state)
                    sIdle: begin
                        if (frameEnd) begin
                            state <= sWait;   // increments still in flight
                        end
                    end
                    sScan: begin
                        if (issue && newReq.rdEn) begin
                            if (nextAddr == lastAddr) begin
                                moreRd <= 1'b0;
                            end else begin
                                nextAddr <= nextAddr + 1'b1;   // runs across pixels
                            end
                        end
                        if (scanEnd) begin
                            state <= sFinish;
                            done <= 1'b1;
                        end
                    end
                    sFinish: begin
                        busy <= 1'b0;
                        state <= sIdle;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmpValid) begin
            maxCount <= bestCount;
            maxBin <= bestBin;
            if (cmpBin == '1) begin
                peak <= '{pixel: cmpPixel, bin: bestBin, count: bestCount};
            end
        end
    end

endmodule

// File: src/histogramTop.sv
`timescale 1ns/1ps

module histogramTop #(
    parameter int pixels = 3
) (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 evValid,
    input  histPkg::hitEvent_t   ev,
    input  logic                 frameEnd,
    output logic                 peakValid,
    output histPkg::peakResult_t peak,
    output logic                 busy,
    output logic                 done
);
    import histPkg::*;

    ramReq_t         accReq;
    ramReq_t         srchReq;
    ramReq_t         ramReq;    // granted request
    logic            accGrant;
    logic            srchGrant;
    logic [cntW-1:0] rdData;    // shared by both peers
    logic            idle;

    binAccumulator #(
        .pixels(pixels)
    ) binAccumulator_inst (
        .clk(clk),
        .res(res),
        .evValid(evValid),
        .ev(ev),
        .accReq(accReq),
        .accGrant(accGrant),
        .rdData(rdData),
        .idle(idle)
    );

    peakSearch #(
        .pixels(pixels)
    ) peakSearch_inst (
        .clk(clk),
        .res(res),
        .frameEnd(frameEnd),
        .idle(idle),
        .srchReq(srchReq),
        .srchGrant(srchGrant),
        .rdData(rdData),
        .peakValid(peakValid),
        .peak(peak),
        .busy(busy),
        .done(done)
    );

    ramArbiter ramArbiter_inst (
        .clk(clk),
        .res(res),
        .accReq(accReq),
        .srchReq(srchReq),
        .accGrant(accGrant),
        .srchGrant(srchGrant),
        .ramReq(ramReq)
    );

    histRam histRam_inst (
        .clk(clk),
        .ramReq(ramReq),
        .rdData(rdData)
    );

endmodule

// File: sim/histogramTop_properties.sv
`timescale 1ns/1ps

module histogramTop_properties (
    input logic             clk,
    input logic             res,
    input logic             accGrant,
    input logic             srchGrant,
    input histPkg::ramReq_t accReq,
    input logic             peakValid,
    input logic             busy,
    input logic             done
);

    // only one peer reaches the RAM per cycle
    grantsExclusive: assert property (@(posedge clk) disable iff (!res)
        !(accGrant && srchGrant))
        else $error("accumulator and search granted together");

    peakInsideBusy: assert property (@(posedge clk) disable iff (!res)
        peakValid |-> busy)
        else $error("peakValid outside busy");

    donePulse: assert property (@(posedge clk) disable iff (!res)
        done |=> !done)
        else $error("done held longer than one cycle");

    // no events are sent during the search
    noIncrementWhileBusy: assert property (@(posedge clk) disable iff (!res)
        busy |-> !accReq.wrEn)
        else $error("accumulator write while busy");

endmodule

bind histogramTop histogramTop_properties histogramTop_properties_inst (
    .clk(clk),
    .res(res),
    .accGrant(accGrant),
    .srchGrant(srchGrant),
    .accReq(accReq),
    .peakValid(peakValid),
    .busy(busy),
    .done(done)
);

// File: sim/histogramTb.sv
`timescale 1ns/1ps

module histogramTb;
    import histPkg::*;

    localparam int pixels = 3;
    localparam int waitLimit = 1000;   // cycles allowed per wait loop
    localparam int countLimit = 4095;  // a bin count stops here

    logic        clk;
    logic        res;
    logic        evValid;
    hitEvent_t   ev;
    logic        frameEnd;
    logic        peakValid;
    peakResult_t peak;
    logic        busy;
    logic        done;

    logic [cntW-1:0] model [0:3][0:63];   // expected counts, pixel by bin
    logic [31:0]     lfsrState;
    int              errors;
    int              testsRun;
    bit              timedOut;

    histogramTop #(
        .pixels(pixels)
    ) histogramTop_inst (
        .clk(clk),
        .res(res),
        .evValid(evValid),
        .ev(ev),
        .frameEnd(frameEnd),
        .peakValid(peakValid),
        .peak(peak),
        .busy(busy),
        .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            val = {val[30:0], lfsrState[0]};   // one step per bit
        end
        return val;
    endfunction

    // first maximum wins, so ties go to the lowest bin
    function automatic peakResult_t expectedPeak(input int p);
        peakResult_t r;
        r.pixel = pixW'(p);
        r.bin = '0;
        r.count = model[p][0];
        for (int b = 1; b < 64; b++) begin
            if (model[p][b] > r.count) begin
                r.bin = binW'(b);
                r.count = model[p][b];
            end
        end
        return r;
    endfunction

    task automatic clearModel();
        for (int p = 0; p < 4; p++) begin
            for (int b = 0; b < 64; b++) begin
                model[p][b] = '0;
            end
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic sendEvent(input int p, input int b);
        ev.pixel = pixW'(p);
        ev.bin = binW'(b);
        evValid = 1'b1;
        if (p < pixels && model[p][b] < countLimit) begin   // drop and saturate
            model[p][b] = model[p][b] + 1'b1;
        end
        idleCycles(1);
        evValid = 1'b0;
    endtask

    task automatic checkPeak(input peakResult_t got, input peakResult_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got pix %0d bin %0d cnt %0d, want pix %0d bin %0d cnt %0d",
                     $time, what, got.pixel, got.bin, got.count, exp.pixel, exp.bin, exp.count);
        end
    endtask

    task automatic checkBusy(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s busy %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic checkFrame(input int seen, input string what);
        if (seen != pixels) begin
            errors++;
            $display("ERROR %0t: %s saw %0d peak results, expected %0d",
                     $time, what, seen, pixels);
        end
    endtask

    // end the frame, collect results until done, then clear the model
    task automatic runFrame(input string what);
        peakResult_t expList [0:3];
        int seen;
        int cycles;
        bit finished;
        bit busyRose;
        for (int p = 0; p < pixels; p++) begin
            expList[p] = expectedPeak(p);
        end
        frameEnd = 1'b1;
        idleCycles(1);
        frameEnd = 1'b0;
        seen = 0;
        cycles = 0;
        finished = 0;
        busyRose = 0;
        while (!finished && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
            busyRose = busyRose || busy;
            if (busyRose || peakValid || done) begin
                checkBusy(busy, 1'b1, what);   // stays high through done
            end
            if (peakValid) begin
                if (seen < pixels) begin
                    checkPeak(peak, expList[seen], what);
                end
                if (peak.pixel >= pixels) begin
                    errors++;
                    $display("ERROR %0t: %s reported unused pixel %0d", $time, what, peak.pixel);
                end
                seen++;
            end
            finished = done;
        end
        if (!finished) begin
            timedOut = 1;
            $display("timeout: %s got no done pulse within %0d cycles", what, waitLimit);
        end else begin
            checkFrame(seen, what);
        end
        clearModel();
        idleCycles(1);
        if (finished) begin
            checkBusy(busy, 1'b0, what);   // drops the cycle after done
        end
    endtask

    task automatic reportTest(input string name, input int mark);
        testsRun++;
        if (errors == mark && !timedOut) begin
            $display("test %0d %s: ok", testsRun, name);
        end else begin
            $display("test %0d %s: FAIL, %0d errors", testsRun, name, errors - mark);
        end
    endtask

    task automatic testOnePerPixel();
        int mark;
        mark = errors;
        for (int p = 0; p < pixels; p++) begin
            sendEvent(p, 10 + 7 * p);
        end
        runFrame("one per pixel");
        reportTest("one per pixel", mark);
    endtask

    task automatic testRandomFrame();
        int mark;
        int p;
        int b;
        mark = errors;
        p = 0;
        b = 0;
        for (int i = 0; i < 400; i++) begin
            if (i == 0 || randBits(2) != 0) begin   // a quarter repeat the last hit
                p = int'(randBits(2));
                b = int'(randBits(6));
            end
            sendEvent(p, b);
            idleCycles(int'(randBits(2)));   // zero gap gives back-to-back hits
        end
        runFrame("random frame");
        reportTest("random frame", mark);
    endtask

    task automatic testTies();
        int mark;
        mark = errors;
        repeat (3) sendEvent(1, 40);   // higher bin filled first
        repeat (3) sendEvent(1, 20);
        repeat (2) sendEvent(1, 5);
        repeat (2) sendEvent(0, 50);
        repeat (2) sendEvent(0, 12);
        sendEvent(2, 63);
        sendEvent(2, 62);
        runFrame("tied bins");
        reportTest("tied bins", mark);
    endtask

    task automatic testSaturation();
        int mark;
        mark = errors;
        sendEvent(0, 3);
        repeat (4100) sendEvent(2, 33);
        runFrame("saturation");
        reportTest("saturation", mark);
    endtask

    task automatic testDroppedPixel();
        int mark;
        int p;
        mark = errors;
        for (int i = 0; i < 200; i++) begin
            if (randBits(1) != 0) begin
                p = 3;   // beyond the pixel count
            end else begin
                p = int'(randBits(2)) % pixels;
            end
            sendEvent(p, int'(randBits(6)));
            idleCycles(int'(randBits(1)));
        end
        runFrame("dropped pixel");
        reportTest("dropped pixel", mark);
    endtask

    task automatic testClearedBins();
        int mark;
        mark = errors;
        for (int i = 0; i < 60; i++) begin
            sendEvent(int'(randBits(2)) % pixels, int'(randBits(6)));
        end
        runFrame("full frame");
        if (!timedOut) begin
            for (int i = 0; i < 20; i++) begin
                sendEvent(0, int'(randBits(6)));
                sendEvent(2, int'(randBits(6)));   // pixel 1 stays empty
            end
            runFrame("empty pixel");
        end
        reportTest("cleared bins", mark);
    endtask

    initial begin
        res = 1'b0;
        evValid = 1'b0;
        ev = '0;
        frameEnd = 1'b0;
        lfsrState = 32'h950f_0dac;
        errors = 0;
        testsRun = 0;
        timedOut = 0;
        clearModel();
        repeat (16) @(posedge clk);
        #1;
        res = 1'b1;
        idleCycles(2);
        if (!timedOut) testOnePerPixel();
        if (!timedOut) testRandomFrame();
        if (!timedOut) testTies();
        if (!timedOut) testSaturation();
        if (!timedOut) testDroppedPixel();
        if (!timedOut) testClearedBins();
        $display("%0d tests run, %0d errors, timeout %0d", testsRun, errors, timedOut);
        if (errors == 0 && !timedOut) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: compile.f
src/histPkg.sv
src/histRam.sv
src/ramArbiter.sv
src/binAccumulator.sv
src/peakSearch.sv
src/histogramTop.sv
sim/histogramTop_properties.sv
sim/histogramTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= histogramTb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAILMSG   ?= tests failed
PASSMSG   ?= all tests passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIMBIN  := $(OBJDIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJDIR LOG VFLAGS"

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

test: $(SIMBIN)
	@./$(SIMBIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASSMSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation ok"

clean:
	rm -rf $(OBJDIR) $(LOG)
